/* Bender.yml */
package:
  name: alu_rs

sources:
  - include_dirs:
      - source
    files:
      - source/rs_pkg.sv
      - source/rs_ifs.sv
      - source/rs_dispatch.sv
      - source/rs_slot.sv
      - source/rs_select_exec.sv
      - source/alu_rs_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/alu_rs_tb.sv

/* source/alu_rs_top.sv */
`default_nettype none

`include "rs_consts.svh"

module alu_rs_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               issue,
  output logic               full,
  input  rs_pkg::rv_opcode_e opcode,
  input  logic [2:0]         funct3,
  input  logic [6:0]         funct7,
  input  rs_pkg::word_t      imm,
  input  rs_pkg::word_t      pc,
  input  rs_pkg::rob_tag_t   issue_rob,
  input  logic               rs1_ready,
  input  rs_pkg::word_t      rs1_value,
  input  rs_pkg::rob_tag_t   rs1_rob,
  input  logic               rs2_ready,
  input  rs_pkg::word_t      rs2_value,
  input  rs_pkg::rob_tag_t   rs2_rob,
  input  logic               ext_cdb_valid,
  input  rs_pkg::rob_tag_t   ext_cdb_rob,
  input  rs_pkg::word_t      ext_cdb_value,
  output logic               result_valid,
  output rs_pkg::word_t      result_value,
  output rs_pkg::rob_tag_t   result_rob
);

  rs_alloc_if alloc_bus ();
  rs_slot_if  slot_bus [`RS_ENTRIES] ();
  cdb_if      cdb_bus ();

  // port 1 comes from the other functional unit
  assign cdb_bus.valid[1] = ext_cdb_valid;
  assign cdb_bus.tag[1]   = ext_cdb_rob;
  assign cdb_bus.value[1] = ext_cdb_value;

  rs_dispatch rs_dispatch_i (
    .issue     (issue),
    .opcode    (opcode),
    .funct3    (funct3),
    .funct7    (funct7),
    .imm       (imm),
    .pc        (pc),
    .issue_rob (issue_rob),
    .rs1_ready (rs1_ready),
    .rs2_ready (rs2_ready),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .rs1_rob   (rs1_rob),
    .rs2_rob   (rs2_rob),
    .full      (full),
    .alloc     (alloc_bus.dispatch),
    .slots     (slot_bus)
  );

  for (genvar g = 0; g < `RS_ENTRIES; g++) begin : g_slot
    rs_slot rs_slot_i (
      .clk    (clk),
      .rst    (rst),
      .alloc  (alloc_bus.slot),
      .my_sel (alloc_bus.sel[g]),
      .cdb    (cdb_bus.sink),
      .slot   (slot_bus[g].slot)
    );
  end

  rs_select_exec rs_select_exec_i (
    .clk          (clk),
    .rst          (rst),
    .slots        (slot_bus),
    .cdb          (cdb_bus.source),
    .result_valid (result_valid),
    .result_value (result_value),
    .result_rob   (result_rob)
  );

endmodule

`default_nettype wire

/* source/rs_consts.svh */
`ifndef RS_CONSTS_SVH
`define RS_CONSTS_SVH

// sizing of the integer ALU reservation station

// number of station slots
`define RS_ENTRIES 8

// reorder-buffer tag width
`define ROB_TAG_W 4

// data path width
`define XLEN 32

// CDB broadcast ports
// port 0 carries this unit's result, port 1 an external unit
`define CDB_PORTS 2

`endif

/* source/rs_dispatch.sv */
`default_nettype none

`include "rs_consts.svh"

module rs_dispatch (
  input  logic                issue,
  input  rs_pkg::rv_opcode_e  opcode,
  input  logic [2:0]          funct3,
  input  logic [6:0]          funct7,
  input  rs_pkg::word_t       imm,
  input  rs_pkg::word_t       pc,
  input  rs_pkg::rob_tag_t    issue_rob,
  input  logic                rs1_ready,
  input  logic                rs2_ready,
  input  rs_pkg::word_t       rs1_value,
  input  rs_pkg::word_t       rs2_value,
  input  rs_pkg::rob_tag_t    rs1_rob,
  input  rs_pkg::rob_tag_t    rs2_rob,
  output logic                full,
  rs_alloc_if.dispatch        alloc,
  rs_slot_if.status           slots [`RS_ENTRIES]
);

  logic [`RS_ENTRIES-1:0] busy_vec;
  logic [`RS_ENTRIES-1:0] free_vec;
  logic [`RS_ENTRIES-1:0] lowest_free;

  // funct3 to execution op; alt is funct7 bit 5
  function automatic rs_pkg::exec_op_e decode_op(input logic [2:0] f3, input logic alt,
                                                 input logic is_reg);
    case (f3)
      3'b000:  decode_op = (alt && is_reg) ? rs_pkg::exe_sub : rs_pkg::exe_add;
      3'b001:  decode_op = rs_pkg::exe_sll;
      3'b010:  decode_op = rs_pkg::exe_slt;
      3'b011:  decode_op = rs_pkg::exe_sltu;
      3'b100:  decode_op = rs_pkg::exe_xor;
      3'b101:  decode_op = alt ? rs_pkg::exe_sra : rs_pkg::exe_srl;
      3'b110:  decode_op = rs_pkg::exe_or;
      default: decode_op = rs_pkg::exe_and;
    endcase
  endfunction

  for (genvar g = 0; g < `RS_ENTRIES; g++) begin : g_busy
    assign busy_vec[g] = slots[g].busy;
  end

  assign full = &busy_vec;

  // isolate the lowest set bit of the free vector
  assign free_vec    = ~busy_vec;
  assign lowest_free = free_vec & (~free_vec + 1'b1);

  assign alloc.sel = (issue && !full) ? lowest_free : '0;

  always_comb begin
    alloc.op        = decode_op(funct3, funct7[5], opcode == rs_pkg::op_reg);
    alloc.dest      = issue_rob;
    alloc.rs1_ready = rs1_ready;
    alloc.rs1_value = rs1_value;
    alloc.rs1_tag   = rs1_rob;
    alloc.rs2_ready = rs2_ready;
    alloc.rs2_value = rs2_value;
    alloc.rs2_tag   = rs2_rob;
    case (opcode)
      rs_pkg::op_lui: begin
        // zero + imm
        alloc.op        = rs_pkg::exe_add;
        alloc.rs1_ready = 1'b1;
        alloc.rs1_value = '0;
        alloc.rs2_ready = 1'b1;
        alloc.rs2_value = imm;
      end
      rs_pkg::op_auipc: begin
        alloc.op        = rs_pkg::exe_add;
        alloc.rs1_ready = 1'b1;
        alloc.rs1_value = pc;
        alloc.rs2_ready = 1'b1;
        alloc.rs2_value = imm;
      end
      rs_pkg::op_imm: begin
        // second operand is the immediate
        alloc.rs2_ready = 1'b1;
        alloc.rs2_value = imm;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/rs_ifs.sv */
`default_nettype none

`include "rs_consts.svh"

// allocation payload, shared by all slots
interface rs_alloc_if;
  logic [`RS_ENTRIES-1:0] sel;
  rs_pkg::exec_op_e       op;
  rs_pkg::rob_tag_t       dest;
  logic                   rs1_ready;
  rs_pkg::word_t          rs1_value;
  rs_pkg::rob_tag_t       rs1_tag;
  logic                   rs2_ready;
  rs_pkg::word_t          rs2_value;
  rs_pkg::rob_tag_t       rs2_tag;

  modport dispatch (
    output sel, op, dest, rs1_ready, rs1_value, rs1_tag, rs2_ready, rs2_value, rs2_tag
  );
  modport slot (
    input sel, op, dest, rs1_ready, rs1_value, rs1_tag, rs2_ready, rs2_value, rs2_tag
  );
endinterface

// per-slot view towards select/exec and dispatch
interface rs_slot_if;
  logic             busy;
  logic             req;
  rs_pkg::exec_op_e op;
  rs_pkg::word_t    a;
  rs_pkg::word_t    b;
  rs_pkg::rob_tag_t dest;
  logic             grant;

  modport slot (output busy, req, op, a, b, dest, input grant);
  modport select (input busy, req, op, a, b, dest, output grant);
  // dispatch only needs occupancy
  modport status (input busy);
endinterface

// common data bus, never stalls
interface cdb_if;
  logic             valid [`CDB_PORTS];
  rs_pkg::rob_tag_t tag   [`CDB_PORTS];
  rs_pkg::word_t    value [`CDB_PORTS];

  modport source (output valid, tag, value);
  modport sink (input valid, tag, value);
endinterface

`default_nettype wire

/* source/rs_pkg.sv */
`default_nettype none

`include "rs_consts.svh"

package rs_pkg;

  // one data word
  typedef logic [`XLEN-1:0] word_t;

  // reorder-buffer tag
  typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

  // RV32I major opcodes handled here
  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
  } rv_opcode_e;

  // operations the execute stage understands
  typedef enum logic [3:0] {
    exe_add,
    exe_sub,
    exe_sll,
    exe_slt,
    exe_sltu,
    exe_xor,
    exe_srl,
    exe_sra,
    exe_or,
    exe_and
  } exec_op_e;

endpackage

`default_nettype wire

/* source/rs_select_exec.sv */
`default_nettype none

`include "rs_consts.svh"

module rs_select_exec (
  input  logic             clk,
  input  logic             rst,
  rs_slot_if.select        slots [`RS_ENTRIES],
  cdb_if.source            cdb,
  output logic             result_valid,
  output rs_pkg::word_t    result_value,
  output rs_pkg::rob_tag_t result_rob
);

  localparam int PTR_W = $clog2(`RS_ENTRIES);

  logic [`RS_ENTRIES-1:0] req_vec;
  logic [`RS_ENTRIES-1:0] gnt_vec;
  rs_pkg::exec_op_e       op_arr   [`RS_ENTRIES];
  rs_pkg::word_t          a_arr    [`RS_ENTRIES];
  rs_pkg::word_t          b_arr    [`RS_ENTRIES];
  rs_pkg::rob_tag_t       dest_arr [`RS_ENTRIES];

  // search start, one past the last grant
  logic [PTR_W-1:0] ptr;
  logic [PTR_W-1:0] pick;
  logic [PTR_W-1:0] idx;
  logic             found;

  rs_pkg::exec_op_e op;
  rs_pkg::word_t    a;
  rs_pkg::word_t    b;
  logic [4:0]       shamt;

  // flatten the interface array so it can be indexed at run time
  for (genvar g = 0; g < `RS_ENTRIES; g++) begin : g_flat
    assign req_vec[g]     = slots[g].req;
    assign op_arr[g]      = slots[g].op;
    assign a_arr[g]       = slots[g].a;
    assign b_arr[g]       = slots[g].b;
    assign dest_arr[g]    = slots[g].dest;
    assign slots[g].grant = gnt_vec[g];
  end

  always_comb begin
    found = 1'b0;
    pick  = ptr;
    for (int i = 0; i < `RS_ENTRIES; i++) begin
      // wraps naturally at the pointer width
      idx = ptr + i[PTR_W-1:0];
      if (!found && req_vec[idx]) begin
        found = 1'b1;
        pick  = idx;
      end
    end
  end

  always_comb begin
    gnt_vec = '0;
    gnt_vec[pick] = found;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (found) begin
      ptr <= pick + 1'b1;
    end
  end

  assign op    = op_arr[pick];
  assign a     = a_arr[pick];
  assign b     = b_arr[pick];
  assign shamt = b[4:0];

  always_comb begin
    case (op)
      rs_pkg::exe_add:  result_value = a + b;
      rs_pkg::exe_sub:  result_value = a - b;
      rs_pkg::exe_sll:  result_value = a << shamt;
      rs_pkg::exe_slt:  result_value = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      rs_pkg::exe_sltu: result_value = {{(`XLEN-1){1'b0}}, a < b};
      rs_pkg::exe_xor:  result_value = a ^ b;
      rs_pkg::exe_srl:  result_value = a >> shamt;
      rs_pkg::exe_sra:  result_value = $unsigned($signed(a) >>> shamt);
      rs_pkg::exe_or:   result_value = a | b;
      default:          result_value = a & b;
    endcase
  end

  assign result_valid = found;
  assign result_rob   = dest_arr[pick];

  // broadcast on port 0
  assign cdb.valid[0] = result_valid;
  assign cdb.tag[0]   = result_rob;
  assign cdb.value[0] = result_value;

endmodule

`default_nettype wire

/* source/rs_slot.sv */
`default_nettype none

`include "rs_consts.svh"

module rs_slot (
  input logic       clk,
  input logic       rst,
  rs_alloc_if.slot  alloc,
  input logic       my_sel,
  cdb_if.sink       cdb,
  rs_slot_if.slot   slot
);

  logic             busy;
  rs_pkg::exec_op_e op;
  rs_pkg::rob_tag_t dest;

  // operand storage, index 0 is rs1
  logic             opr_rdy [2];
  rs_pkg::word_t    opr_val [2];
  rs_pkg::rob_tag_t opr_tag [2];

  logic             base_rdy [2];
  rs_pkg::word_t    base_val [2];
  rs_pkg::rob_tag_t base_tag [2];
  logic             nxt_rdy  [2];
  rs_pkg::word_t    nxt_val  [2];

  always_comb begin
    if (my_sel) begin
      base_rdy[0] = alloc.rs1_ready;
      base_val[0] = alloc.rs1_value;
      base_tag[0] = alloc.rs1_tag;
      base_rdy[1] = alloc.rs2_ready;
      base_val[1] = alloc.rs2_value;
      base_tag[1] = alloc.rs2_tag;
    end else begin
      base_rdy = opr_rdy;
      base_val = opr_val;
      base_tag = opr_tag;
    end
    // wakeup, also applied to a payload being allocated
    for (int k = 0; k < 2; k++) begin
      nxt_rdy[k] = base_rdy[k];
      nxt_val[k] = base_val[k];
      for (int p = 0; p < `CDB_PORTS; p++) begin
        if (!base_rdy[k] && cdb.valid[p] && cdb.tag[p] == base_tag[k]) begin
          nxt_rdy[k] = 1'b1;
          nxt_val[k] = cdb.value[p];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
    end else if (my_sel) begin
      busy <= 1'b1;
    end else if (slot.grant) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (my_sel) begin
      op   <= alloc.op;
      dest <= alloc.dest;
    end
    if (my_sel || busy) begin
      opr_rdy <= nxt_rdy;
      opr_val <= nxt_val;
      opr_tag <= base_tag;
    end
  end

  assign slot.busy = busy;
  assign slot.req  = busy && opr_rdy[0] && opr_rdy[1];
  assign slot.op   = op;
  assign slot.a    = opr_val[0];
  assign slot.b    = opr_val[1];
  assign slot.dest = dest;

endmodule

`default_nettype wire

/* verif/alu_rs_tb.sv */
`default_nettype none

`include "rs_consts.svh"

module alu_rs_tb;

  localparam int N_INSTR = 400;
  localparam int NTAGS   = 16;
  localparam int TIMEOUT = N_INSTR * 24 + 200;

  logic               clk;
  logic               rst;
  logic               issue;
  logic               full;
  rs_pkg::rv_opcode_e opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  rs_pkg::word_t      imm;
  rs_pkg::word_t      pc;
  rs_pkg::rob_tag_t   issue_rob;
  logic               rs1_ready;
  rs_pkg::word_t      rs1_value;
  rs_pkg::rob_tag_t   rs1_rob;
  logic               rs2_ready;
  rs_pkg::word_t      rs2_value;
  rs_pkg::rob_tag_t   rs2_rob;
  logic               ext_cdb_valid;
  rs_pkg::rob_tag_t   ext_cdb_rob;
  rs_pkg::word_t      ext_cdb_value;
  logic               result_valid;
  rs_pkg::word_t      result_value;
  rs_pkg::rob_tag_t   result_rob;

  // per-tag model where state 0 is free, 1 in the station, 2 an external producer
  logic [1:0]         tstate  [NTAGS];
  rs_pkg::rv_opcode_e m_opc   [NTAGS];
  logic [2:0]         m_f3    [NTAGS];
  logic               m_alt   [NTAGS];
  logic               opr_ok  [NTAGS][2];
  rs_pkg::word_t      opr_val [NTAGS][2];
  rs_pkg::rob_tag_t   opr_tag [NTAGS][2];
  rs_pkg::word_t      ext_val [NTAGS];

  integer           seed;
  int               cyc;
  int               issued;
  int               busy_cnt;
  int               ext_cnt;
  int               issued_now;
  int               fast_due;
  rs_pkg::rob_tag_t fast_tag;
  logic             hold_ext;

  alu_rs_top alu_rs_top_i (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT) begin
      $display("run timed out after %0d cycles", cyc);
      end_failed();
    end
  end

  task automatic end_failed();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    end_failed();
  endtask

  task automatic check_word(input string name, input rs_pkg::word_t exp,
                            input rs_pkg::word_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      end_failed();
    end
  endtask

  task automatic check_tag(input string name, input rs_pkg::rob_tag_t exp,
                           input rs_pkg::rob_tag_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      end_failed();
    end
  endtask

  task automatic check_logic(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      end_failed();
    end
  endtask

  // RV32I semantics of the accepted instructions
  function automatic rs_pkg::word_t model_alu(input rs_pkg::rv_opcode_e opc,
                                              input logic [2:0] f3, input logic alt,
                                              input rs_pkg::word_t a, input rs_pkg::word_t b);
    logic [4:0]        sh;
    logic signed [31:0] sra_v;
    sh    = b[4:0];
    sra_v = $signed(a) >>> sh;
    if (opc == rs_pkg::op_lui) return b;
    if (opc == rs_pkg::op_auipc) return a + b;
    case (f3)
      3'd0:    return (alt && opc == rs_pkg::op_reg) ? a - b : a + b;
      3'd1:    return a << sh;
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? sra_v : a >> sh;
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // kind 0 free, 1 any tag in flight, 2 pending external
  task automatic pick_tag(input logic [1:0] kind, output rs_pkg::rob_tag_t tag,
                          output logic found);
    int cand [$];
    for (int t = 0; t < NTAGS; t++) begin
      if ((kind == 2'd0 && tstate[t] == 2'd0) || (kind == 2'd1 && tstate[t] != 2'd0) ||
          (kind == 2'd2 && tstate[t] == 2'd2))
        cand.push_back(t);
    end
    found = cand.size() != 0;
    tag   = '0;
    if (found) tag = cand[$unsigned($random(seed)) % cand.size()];
  endtask

  // mode 0 random, 1 ready, 2 waits on a new external producer
  task automatic choose_operand(input logic [1:0] mode, output logic rdy,
                                output rs_pkg::word_t val, output rs_pkg::rob_tag_t tag);
    int   r;
    logic ok;
    r   = $unsigned($random(seed)) % 4;
    rdy = 1'b1;
    val = $random(seed);
    tag = $random(seed);
    if (mode == 2'd2 || (mode == 2'd0 && r == 1 && ext_cnt < 4)) begin
      pick_tag(2'd0, tag, ok);
      tstate[tag]  = 2'd2;
      ext_val[tag] = $random(seed);
      ext_cnt++;
      rdy = 1'b0;
    end else if (mode == 2'd0 && r == 0) begin
      pick_tag(2'd1, tag, ok);
      rdy = !ok;
    end
  endtask

  task automatic issue_one(input logic [1:0] mode);
    rs_pkg::rob_tag_t t;
    logic             ok;
    logic             alt;
    int               r;
    r = $unsigned($random(seed)) % 8;
    if (mode == 2'd2) r = 7;
    case (r)
      0:       opcode = rs_pkg::op_lui;
      1:       opcode = rs_pkg::op_auipc;
      2, 3, 4: opcode = rs_pkg::op_imm;
      default: opcode = rs_pkg::op_reg;
    endcase
    alt    = $random(seed);
    funct3 = $random(seed);
    funct7 = {1'b0, alt, 5'b00000};
    imm    = $random(seed);
    pc     = $random(seed);
    choose_operand(mode, rs1_ready, rs1_value, rs1_rob);
    choose_operand((mode == 2'd2) ? 2'd1 : mode, rs2_ready, rs2_value, rs2_rob);
    pick_tag(2'd0, t, ok);
    if (!ok) report_error("no free tag left for a new instruction");
    tstate[t]     = 2'd1;
    m_opc[t]      = opcode;
    m_f3[t]       = funct3;
    m_alt[t]      = alt;
    opr_ok[t][0]  = rs1_ready;
    opr_val[t][0] = rs1_value;
    opr_tag[t][0] = rs1_rob;
    opr_ok[t][1]  = rs2_ready;
    opr_val[t][1] = rs2_value;
    opr_tag[t][1] = rs2_rob;
    // operands the dispatcher supplies itself
    if (opcode == rs_pkg::op_lui || opcode == rs_pkg::op_auipc) begin
      opr_ok[t][0]  = 1'b1;
      opr_val[t][0] = (opcode == rs_pkg::op_lui) ? '0 : pc;
    end
    if (opcode != rs_pkg::op_reg) begin
      opr_ok[t][1]  = 1'b1;
      opr_val[t][1] = imm;
    end
    // empty station and nothing to wait for
    if (busy_cnt == 0 && opr_ok[t][0] && opr_ok[t][1]) begin
      fast_due = cyc + 1;
      fast_tag = t;
    end
    issue_rob  = t;
    issue      = 1'b1;
    issued_now = 1;
    issued++;
  endtask

  task automatic broadcast_ext();
    rs_pkg::rob_tag_t t;
    logic             ok;
    pick_tag(2'd2, t, ok);
    if (ok) begin
      ext_cdb_valid = 1'b1;
      ext_cdb_rob   = t;
      ext_cdb_value = ext_val[t];
    end
  endtask

  // wake every waiting operand and free the tag
  task automatic resolve(input rs_pkg::rob_tag_t tag, input rs_pkg::word_t val);
    for (int t = 0; t < NTAGS; t++) begin
      for (int k = 0; k < 2; k++) begin
        if (tstate[t] == 2'd1 && !opr_ok[t][k] && opr_tag[t][k] == tag) begin
          opr_ok[t][k]  = 1'b1;
          opr_val[t][k] = val;
        end
      end
    end
    tstate[tag] = 2'd0;
  endtask

  task automatic sample_cycle();
    rs_pkg::rob_tag_t t;
    rs_pkg::word_t    exp;
    int               ret_now;
    ret_now = 0;
    check_logic("full", busy_cnt == `RS_ENTRIES, full);
    if (busy_cnt == 0 || hold_ext) check_logic("result_valid", 1'b0, result_valid);
    if (fast_due == cyc) begin
      check_logic("result_valid", 1'b1, result_valid);
      check_tag("result_rob", fast_tag, result_rob);
    end
    if (result_valid === 1'b1) begin
      t = result_rob;
      if (tstate[t] !== 2'd1) report_error("result for a tag that is not in the station");
      if (!opr_ok[t][0] || !opr_ok[t][1]) report_error("result before its operands are known");
      exp = model_alu(m_opc[t], m_f3[t], m_alt[t], opr_val[t][0], opr_val[t][1]);
      check_word("result_value", exp, result_value);
      resolve(t, exp);
      ret_now = 1;
    end
    if (ext_cdb_valid) begin
      resolve(ext_cdb_rob, ext_cdb_value);
      ext_cnt--;
    end
    busy_cnt   = busy_cnt + issued_now - ret_now;
    issued_now = 0;
  endtask

  task automatic begin_cycle();
    @(posedge clk);
    #1;
    issue         = 1'b0;
    ext_cdb_valid = 1'b0;
  endtask

  task automatic run_until_idle(input int n);
    while (issued < n || busy_cnt != 0 || ext_cnt != 0) begin
      begin_cycle();
      if (issued < n && busy_cnt < `RS_ENTRIES && ($random(seed) & 1))
        issue_one((issued == 0) ? 2'd1 : 2'd0);
      if (ext_cnt != 0 && ($unsigned($random(seed)) % 3 == 0))
        broadcast_ext();
      #2;
      sample_cycle();
    end
  endtask

  initial begin
    seed          = 23;
    cyc           = 0;
    issued        = 0;
    busy_cnt      = 0;
    ext_cnt       = 0;
    issued_now    = 0;
    fast_due      = -1;
    fast_tag      = '0;
    hold_ext      = 1'b0;
    for (int t = 0; t < NTAGS; t++) tstate[t] = 2'd0;
    clk           = 1'b0;
    rst           = 1'b1;
    issue         = 1'b0;
    opcode        = rs_pkg::op_reg;
    funct3        = '0;
    funct7        = '0;
    imm           = '0;
    pc            = '0;
    issue_rob     = '0;
    rs1_ready     = 1'b0;
    rs1_value     = '0;
    rs1_rob       = '0;
    rs2_ready     = 1'b0;
    rs2_value     = '0;
    rs2_rob       = '0;
    ext_cdb_valid = 1'b0;
    ext_cdb_rob   = '0;
    ext_cdb_value = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    #2;
    check_logic("full", 1'b0, full);
    check_logic("result_valid", 1'b0, result_valid);

    run_until_idle(N_INSTR);

    // fill the station with instructions held on external tags
    hold_ext = 1'b1;
    repeat (`RS_ENTRIES) begin
      begin_cycle();
      issue_one(2'd2);
      #2;
      sample_cycle();
    end
    repeat (3) begin
      begin_cycle();
      #2;
      sample_cycle();
    end
    check_logic("full", 1'b1, full);
    hold_ext = 1'b0;
    run_until_idle(issued);

    // station stays quiet once every tag has retired
    repeat (2) begin
      begin_cycle();
      #2;
      sample_cycle();
    end

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+source
source/rs_pkg.sv
source/rs_ifs.sv
source/rs_dispatch.sv
source/rs_slot.sv
source/rs_select_exec.sv
source/alu_rs_top.sv
verif/alu_rs_tb.sv
